// File: bus_arbiter.sv
// ----------------------------------------------------------------------
// read/write bus arbiter between the emio bridge and one other master
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module bus_arbiter import emio_pkg::*; (
    input  logic     sysclk,
    input  logic     rst_n,
    input  bus_req_t emio_req,
    input  bus_req_t ext_req,
    output bus_req_t emio_grant,
    output bus_req_t ext_grant
);

    localparam logic [1:0] own_none = 2'd0;
    localparam logic [1:0] own_emio = 2'd1;
    localparam logic [1:0] own_ext  = 2'd2;

    logic [1:0] rd_owner, wr_owner;

    // owner held while its request stays up, other master wins a free bus
    function automatic logic [1:0] next_owner(input logic [1:0] owner,
                                              input logic emio_r,
                                              input logic ext_r);
        logic [1:0] nxt;
        nxt = owner;
        case (owner)
            own_emio: nxt = emio_r ? own_emio : own_none;
            own_ext:  nxt = ext_r ? own_ext : own_none;
            default: begin
                if (ext_r)
                    nxt = own_ext;
                else if (emio_r)
                    nxt = own_emio;
            end
        endcase
        return nxt;
    endfunction

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            rd_owner <= own_none;
            wr_owner <= own_none;
        end else begin
            rd_owner <= next_owner(rd_owner, emio_req.rd, ext_req.rd);
            wr_owner <= next_owner(wr_owner, emio_req.wr, ext_req.wr);
        end
    end

    assign emio_grant = '{rd: rd_owner == own_emio, wr: wr_owner == own_emio};
    assign ext_grant  = '{rd: rd_owner == own_ext, wr: wr_owner == own_ext};

    // a bus passes between the masters only through a free cycle
    a_free_handover: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(ext_grant.rd && $past(emio_grant.rd)) && !(emio_grant.rd && $past(ext_grant.rd)) &&
        !(ext_grant.wr && $past(emio_grant.wr)) && !(emio_grant.wr && $past(ext_grant.wr)));

endmodule

// File: emio_bus.sv
// ----------------------------------------------------------------------
// emio bridge: decodes PS requests on the EMIO port and drives the
// register bus read/write requests, addresses, data and strobes
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "emio_cfg.svh"

module emio_bus import emio_pkg::*; (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic [3:0]              board_id,
    input  logic [63:0]             emio_ps_out,
    input  logic [63:0]             emio_ps_tri,
    input  bus_req_t                grant,
    input  logic [`EMIO_DATA_W-1:0] rdata,
    input  logic                    rvalid,
    input  logic [31:0]             timestamp,
    output logic [63:0]             emio_ps_in,
    output bus_req_t                req,
    output logic [`EMIO_ADDR_W-1:0] raddr,
    output reg_wr_t                 wr,
    output logic                    blk_wen,
    output logic                    blk_wstart,
    output logic                    blk_rt_rd,
    output logic                    blk_rt_wr,
    output logic                    req_blk_rt_rd
);

    ps_cmd_t                 cmd;
    logic                    ps_write;
    logic                    req_s1, req_s2;
    logic [`EMIO_ADDR_W-1:0] addr_l;
    logic                    blk_start_l, blk_end_l;
    logic                    rvalid_q;
    emio_state_e             state;
    logic [`EMIO_ADDR_W-1:0] reg_addr;
    logic                    reg_addr_lsb;
    logic [`EMIO_DATA_W-1:0] reg_wdata, rdata_l;
    logic                    reg_wen, wen_next;
    logic                    op_done, op_done_next, rd_next;
    logic [1:0]              blk_cnt;
    logic                    first_quad;
    logic [31:0]             ts_delta, ts_prev;

    // bits 49 and 63:53 of emio_ps_out carry nothing
    assign cmd = '{blk_end: emio_ps_out[52], blk_start: emio_ps_out[51],
                   wen: emio_ps_out[50], req: emio_ps_out[48],
                   addr: emio_ps_out[47:32], wdata: emio_ps_out[31:0]};

    // all data lines driven by the PS means a write
    assign ps_write = (emio_ps_tri[31:0] == 32'd0);

    logic req_rise, req_fall, addr_next, addr_same, addr_main, addr_hub_trig, ts_rd;
    logic [11:0] addr_inc;
    assign req_rise      = req_s1 & ~req_s2;
    assign req_fall      = ~req_s1 & req_s2;
    // PS moves to the next quadlet by toggling the address lsb
    assign addr_next     = (addr_l[0] != reg_addr_lsb);
    assign addr_same     = (cmd.addr == addr_l) & ~addr_next;
    assign addr_main     = (addr_l[15:12] == `ADDR_MAIN);
    assign addr_hub_trig = (addr_l == `HUB_TRIG_ADDR);
    assign addr_inc      = reg_addr[11:0] + 12'd1;
    // quadlet 0 of a real-time block read is the timestamp delta
    assign ts_rd         = blk_rt_rd && (reg_addr[7:0] == 8'd0);

    assign raddr = reg_addr;
    assign wr    = '{addr: reg_addr, data: reg_wdata, wen: reg_wen};

    assign emio_ps_in = {`EMIO_VERSION, 5'd0,
                         ps_write ? grant.wr : grant.rd,
                         ps_write,
                         cmd.blk_end, cmd.blk_start, cmd.wen,
                         op_done & addr_same,
                         cmd.req, cmd.addr,
                         ps_write ? cmd.wdata : rdata_l};

    // input sampling into sysclk
    always_ff @(posedge sysclk) begin
        addr_l      <= cmd.addr;
        blk_start_l <= cmd.blk_start;
        blk_end_l   <= cmd.blk_end;
        rvalid_q    <= rvalid;
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            req_s1        <= 1'b0;
            req_s2        <= 1'b0;
            state         <= st_idle;
            req           <= '0;
            reg_addr_lsb  <= 1'b0;
            reg_wen       <= 1'b0;
            wen_next      <= 1'b0;
            op_done       <= 1'b0;
            op_done_next  <= 1'b0;
            rd_next       <= 1'b0;
            blk_cnt       <= 2'd0;
            first_quad    <= 1'b0;
            blk_wen       <= 1'b0;
            blk_wstart    <= 1'b0;
            blk_rt_rd     <= 1'b0;
            blk_rt_wr     <= 1'b0;
            req_blk_rt_rd <= 1'b0;
            ts_prev       <= 32'd0;
        end else begin
            // two-flop sync of the PS request
            req_s1        <= cmd.req;
            req_s2        <= req_s1;
            req_blk_rt_rd <= 1'b0;
            if (req_fall) begin
                // PS dropped req, ends or aborts any operation
                state      <= st_idle;
                req        <= '0;
                reg_wen    <= 1'b0;
                op_done    <= 1'b0;
                blk_wen    <= 1'b0;
                blk_wstart <= 1'b0;
                blk_rt_rd  <= 1'b0;
                blk_rt_wr  <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        op_done    <= 1'b0;
                        reg_wen    <= 1'b0;
                        blk_wen    <= 1'b0;
                        blk_wstart <= 1'b0;
                        blk_cnt    <= 2'd0;
                        if (req_rise) begin
                            first_quad   <= 1'b1;
                            reg_addr_lsb <= addr_l[0];
                            // hub trigger on rt block read or hub 800 write
                            if ((!ps_write && blk_start_l && addr_main) ||
                                (ps_write && addr_hub_trig)) begin
                                req_blk_rt_rd <= 1'b1;
                                ts_delta      <= timestamp - ts_prev - 32'd1;
                                ts_prev       <= timestamp;
                            end
                            if (!ps_write) begin
                                req.rd    <= 1'b1;
                                rd_next   <= blk_start_l & ~blk_end_l;
                                reg_addr  <= addr_l;
                                blk_rt_rd <= blk_start_l & addr_main;
                                state     <= st_read;
                            end else begin
                                req.wr    <= 1'b1;
                                // rt block write always starts at offset 0
                                reg_addr  <= {addr_l[15:12],
                                              (blk_start_l && addr_main) ? 12'd0 : addr_l[11:0]};
                                blk_rt_wr <= blk_start_l & addr_main;
                                reg_wdata <= cmd.wdata;
                                state     <= blk_start_l ? st_write_blk_start : st_write_quad;
                            end
                        end else begin
                            req <= '0;
                        end
                    end
                    st_read: begin
                        // stays here until req falls
                        if (req.rd && grant.rd) begin
                            if (addr_next) begin
                                reg_addr[11:0] <= addr_inc;
                                reg_addr_lsb   <= addr_l[0];
                                op_done        <= 1'b0;
                                rd_next        <= blk_start_l & ~blk_end_l;
                            end else if (rvalid && rvalid_q) begin
                                rdata_l <= ts_rd ? ts_delta : rdata;
                                op_done <= 1'b1;
                                req.rd  <= rd_next;
                            end
                        end
                    end
                    st_write_quad: begin
                        if (req.wr && grant.wr) begin
                            reg_wen <= 1'b1;
                            state   <= st_write_finish;
                        end
                    end
                    st_write_blk_start: begin
                        // four blk_wstart cycles with the bus held
                        if (req.wr && grant.wr) begin
                            blk_wstart <= 1'b1;
                            blk_cnt    <= blk_cnt + 2'd1;
                            if (blk_cnt == 2'd3)
                                state <= st_write_blk_data;
                        end else begin
                            blk_cnt <= 2'd0;
                        end
                    end
                    st_write_blk_data: begin
                        if (req.wr && grant.wr) begin
                            blk_wstart <= 1'b0;
                            if (first_quad) begin
                                first_quad   <= 1'b0;
                                reg_wen      <= 1'b1;
                                wen_next     <= 1'b0;
                                op_done_next <= ~blk_end_l;
                                blk_cnt      <= 2'd1;
                            end else if (addr_next) begin
                                // new quadlet from the PS
                                reg_addr[11:0] <= addr_inc;
                                reg_addr_lsb   <= addr_l[0];
                                reg_wdata      <= cmd.wdata;
                                reg_wen        <= 1'b0;
                                wen_next       <= 1'b1;
                                op_done        <= 1'b0;
                                op_done_next   <= ~blk_end_l;
                                blk_cnt        <= 2'd0;
                            end else begin
                                reg_wen  <= wen_next;
                                wen_next <= 1'b0;
                                op_done  <= op_done_next & ~wen_next;
                                blk_cnt  <= blk_cnt + 2'd1;
                                // last quadlet written, close the block
                                if (blk_cnt == 2'd3 && !op_done_next) begin
                                    blk_wen <= 1'b1;
                                    state   <= st_write_finish;
                                end
                            end
                        end else begin
                            blk_cnt <= 2'd0;
                        end
                    end
                    st_write_finish: begin
                        reg_wen <= 1'b0;
                        blk_wen <= 1'b0;
                        req.wr  <= 1'b0;
                        op_done <= 1'b1;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // bridge owns at most one direction at a time
    a_one_dir: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(req.rd && req.wr));

    // a write strobe only follows a cycle with the write bus granted
    a_wen_granted: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(reg_wen) |-> $past(grant.wr));

endmodule

// File: emio_cfg.svh
// ----------------------------------------------------------------------
// emio bridge configuration: widths, region codes, bank size, version
// ----------------------------------------------------------------------
`ifndef EMIO_CFG_SVH
`define EMIO_CFG_SVH

// register bus address and quadlet widths
`define EMIO_ADDR_W 16
`define EMIO_DATA_W 32

// region codes in address bits [15:12]
`define ADDR_MAIN 4'h0
`define ADDR_HUB 4'h1

// hub register whose write triggers a real-time block read request
`define HUB_TRIG_ADDR {`ADDR_HUB, 12'h800}

// quadlets stored per region in the register bank
`define BANK_DEPTH 64

// reported to the PS in emio_ps_in[63:60]
`define EMIO_VERSION 4'd4

`endif

// File: emio_pkg.sv
// ----------------------------------------------------------------------
// emio bridge package: shared command, bus and state types
// ----------------------------------------------------------------------
`include "emio_cfg.svh"

package emio_pkg;

    // command fields the PS places on emio_ps_out
    typedef struct packed {
        logic                    blk_end;
        logic                    blk_start;
        logic                    wen;
        logic                    req;
        logic [`EMIO_ADDR_W-1:0] addr;
        logic [`EMIO_DATA_W-1:0] wdata;
    } ps_cmd_t;

    // one register bus write
    typedef struct packed {
        logic [`EMIO_ADDR_W-1:0] addr;
        logic [`EMIO_DATA_W-1:0] data;
        logic                    wen;
    } reg_wr_t;

    // read/write bus request, also used for the grant
    typedef struct packed {
        logic rd;
        logic wr;
    } bus_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_write_quad,
        st_write_blk_start,
        st_write_blk_data,
        st_write_finish
    } emio_state_e;

endpackage

// File: emio_top.sv
// ----------------------------------------------------------------------
// emio subsystem top: bridge, write translation, arbiter, register bank
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "emio_cfg.svh"

module emio_top import emio_pkg::*; (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic [3:0]  board_id,
    input  logic [63:0] emio_ps_out,
    input  logic [63:0] emio_ps_tri,
    input  logic [31:0] timestamp,
    input  bus_req_t    ext_req,
    output logic [63:0] emio_ps_in,
    output bus_req_t    ext_grant,
    output logic        blk_wen,
    output logic        blk_wstart,
    output logic        blk_rt_rd,
    output logic        blk_rt_wr,
    output logic        req_blk_rt_rd
);

    bus_req_t                emio_req, emio_grant;
    reg_wr_t                 wr_raw, wr_xl;
    logic [`EMIO_ADDR_W-1:0] raddr;
    logic [`EMIO_DATA_W-1:0] rdata;
    logic                    rvalid;

    emio_bus u_emio_bus (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .emio_ps_out(emio_ps_out), .emio_ps_tri(emio_ps_tri),
        .grant(emio_grant), .rdata(rdata), .rvalid(rvalid), .timestamp(timestamp),
        .emio_ps_in(emio_ps_in), .req(emio_req), .raddr(raddr), .wr(wr_raw),
        .blk_wen(blk_wen), .blk_wstart(blk_wstart), .blk_rt_rd(blk_rt_rd),
        .blk_rt_wr(blk_rt_wr), .req_blk_rt_rd(req_blk_rt_rd)
    );

    write_addr_xlate u_xlate (
        .sysclk(sysclk), .rst_n(rst_n), .wr_in(wr_raw),
        .blk_rt_wr(blk_rt_wr), .board_id(board_id), .wr_out(wr_xl)
    );

    bus_arbiter u_arb (
        .sysclk(sysclk), .rst_n(rst_n), .emio_req(emio_req), .ext_req(ext_req),
        .emio_grant(emio_grant), .ext_grant(ext_grant)
    );

    reg_bank u_bank (
        .sysclk(sysclk), .rst_n(rst_n), .wr(wr_xl),
        .raddr(raddr), .rdata(rdata), .rvalid(rvalid)
    );

endmodule

// File: reg_bank.sv
// ----------------------------------------------------------------------
// board register store: main and hub regions, registered read path
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "emio_cfg.svh"

module reg_bank import emio_pkg::*; (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  reg_wr_t                 wr,
    input  logic [`EMIO_ADDR_W-1:0] raddr,
    output logic [`EMIO_DATA_W-1:0] rdata,
    output logic                    rvalid
);

    localparam int idx_w = $clog2(`BANK_DEPTH);

    logic [`EMIO_DATA_W-1:0] main_mem [`BANK_DEPTH];
    logic [`EMIO_DATA_W-1:0] hub_mem  [`BANK_DEPTH];
    logic [idx_w-1:0]        widx, ridx;
    logic [`EMIO_ADDR_W-1:0] raddr_q;
    logic                    stable_q;

    // address bit 12 picks the hub region
    assign widx = wr.addr[idx_w-1:0];
    assign ridx = raddr[idx_w-1:0];

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BANK_DEPTH; i++) begin
                main_mem[i] <= '0;
                hub_mem[i]  <= '0;
            end
        end else if (wr.wen) begin
            if (wr.addr[12])
                hub_mem[widx] <= wr.data;
            else
                main_mem[widx] <= wr.data;
        end
    end

    always_ff @(posedge sysclk) begin
        rdata <= raddr[12] ? hub_mem[ridx] : main_mem[ridx];
    end

    // valid once raddr has held for a full cycle of registered data
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            raddr_q  <= '0;
            stable_q <= 1'b0;
        end else begin
            raddr_q  <= raddr;
            stable_q <= (raddr == raddr_q);
        end
    end

    // drops at once when raddr moves
    assign rvalid = stable_q && (raddr == raddr_q);

endmodule

// File: tb.f
+incdir+.
emio_pkg.sv
emio_bus.sv
write_addr_xlate.sv
bus_arbiter.sv
reg_bank.sv
emio_top.sv
tb_emio.sv

// File: tb_emio.sv
// ----------------------------------------------------------------------
// emio subsystem testbench: PS driver, register model, random tests
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "emio_cfg.svh"

module tb_emio import emio_pkg::*; ();

    logic        sysclk, rst_n;
    logic [3:0]  board_id;
    logic [63:0] emio_ps_out, emio_ps_tri, emio_ps_in;
    logic [31:0] timestamp, ext_rnd, prev_ts, exp_delta;
    bus_req_t    ext_req, ext_grant;
    logic        blk_wen, blk_wstart, blk_rt_rd, blk_rt_wr, req_blk_rt_rd;
    logic [31:0] model [2*`BANK_DEPTH];
    logic [15:0] wr_addrs [30];
    int          errors, checks, cycles, pulse_cnt, wstart_cnt, bwen_cnt;
    bit          contend;

    emio_top uut (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .emio_ps_out(emio_ps_out), .emio_ps_tri(emio_ps_tri), .timestamp(timestamp),
        .ext_req(ext_req), .emio_ps_in(emio_ps_in), .ext_grant(ext_grant),
        .blk_wen(blk_wen), .blk_wstart(blk_wstart), .blk_rt_rd(blk_rt_rd),
        .blk_rt_wr(blk_rt_wr), .req_blk_rt_rd(req_blk_rt_rd)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    // free-running timestamp, also the model's time base
    always @(posedge sysclk) timestamp <= timestamp + 32'd1;

    // other master: short random bursts on both buses
    always @(posedge sysclk) begin
        if (!contend) begin
            ext_req <= '0;
        end else begin
            ext_rnd = $urandom;
            ext_req.rd <= ext_req.rd ? (ext_rnd[1:0] != 0) : (ext_rnd[7:4] == 0);
            ext_req.wr <= ext_req.wr ? (ext_rnd[9:8] != 0) : (ext_rnd[15:12] == 0);
        end
    end

    // run limit, about 200 operations of 30 cycles
    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= 6000) begin
            $display("run stopped at the cycle limit of %0d", cycles);
            $display("checks %0d errors %0d", checks, errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    task report(input string msg);
        errors++;
        $display("%0t %s", $time, msg);
    endtask

    task check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // trigger pulses, timestamp delta model and strobe counts
    always @(negedge sysclk) begin
        if (rst_n) begin
            if (req_blk_rt_rd) begin
                pulse_cnt++;
                // the bridge sampled the value before this edge's increment
                exp_delta = (timestamp - 32'd1) - prev_ts - 32'd1;
                prev_ts   = timestamp - 32'd1;
            end
            if (blk_wstart)
                wstart_cnt++;
            if (blk_wen)
                bwen_cnt++;
            assert (!(ext_grant.rd && uut.emio_grant.rd) && !(ext_grant.wr && uut.emio_grant.wr))
                else report("other master and bridge both hold the same bus");
        end
    end

    function automatic int idx(input logic [15:0] a);
        return {a[12], a[5:0]};
    endfunction

    function automatic logic [15:0] rand_addr();
        return $urandom & 16'h103f;
    endfunction

    // field layout of emio_ps_out, bit 49 unused
    function automatic logic [63:0] pack_cmd(input ps_cmd_t c);
        return {11'd0, c.blk_end, c.blk_start, c.wen, 1'b0, c.req, c.addr, c.wdata};
    endfunction

    task drive_ps(input ps_cmd_t c, input bit is_wr);
        @(posedge sysclk);
        emio_ps_out <= pack_cmd(c);
        emio_ps_tri <= is_wr ? 64'd0 : {64{1'b1}};
    endtask

    task wait_done(input ps_cmd_t c, input bit is_wr, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 300 && !ok; n++) begin
            @(negedge sysclk);
            ok = emio_ps_in[49];
        end
        if (!ok) begin
            report("op_done never came for the pending operation");
        end else begin
            check_val("emio_ps_in[53]", emio_ps_in[53], is_wr);
            check_val("emio_ps_in[54]", emio_ps_in[54], 1);
            check_val("emio_ps_in[63:60]", emio_ps_in[63:60], `EMIO_VERSION);
            // command echo with op_done in bit 49
            check_val("emio_ps_in[52:48]", emio_ps_in[52:48],
                      {c.blk_end, c.blk_start, c.wen, 1'b1, c.req});
            check_val("emio_ps_in[47:32]", emio_ps_in[47:32], c.addr);
            if (is_wr)
                check_val("emio_ps_in[31:0]", emio_ps_in[31:0], c.wdata);
        end
    endtask

    // drop req and let the bridge return to idle
    task end_op(input ps_cmd_t c, input bit is_wr);
        c.req = 1'b0;
        drive_ps(c, is_wr);
        repeat (4) @(posedge sysclk);
    endtask

    function automatic ps_cmd_t make_cmd(input logic [15:0] a, input logic [31:0] d,
                                         input bit is_wr, input bit blk, input bit last);
        ps_cmd_t c;
        c.blk_end   = last;
        c.blk_start = blk;
        c.wen       = is_wr;
        c.req       = 1'b1;
        c.addr      = a;
        c.wdata     = d;
        return c;
    endfunction

    task quad_write(input logic [15:0] a, input logic [31:0] d);
        ps_cmd_t c;
        bit      ok;
        int      b0;
        b0 = bwen_cnt;
        c  = make_cmd(a, d, 1, 0, 0);
        drive_ps(c, 1);
        wait_done(c, 1, ok);
        end_op(c, 1);
        if (ok)
            model[idx(a)] = d;
        // blk_wen belongs to block writes only
        check_val("blk_wen pulses", bwen_cnt - b0, 0);
    endtask

    task read_check(input logic [15:0] a);
        ps_cmd_t c;
        bit      ok;
        c = make_cmd(a, 32'd0, 0, 0, 0);
        drive_ps(c, 0);
        wait_done(c, 0, ok);
        if (ok)
            check_val("emio_ps_in[31:0]", emio_ps_in[31:0], model[idx(a)]);
        end_op(c, 0);
    endtask

    // each further quadlet toggles the address lsb
    task blk_read(input logic [15:0] base, input int n, input bit rt);
        ps_cmd_t     c;
        bit          ok;
        logic [31:0] exp;
        ok = 1'b1;
        for (int k = 0; k < n && ok; k++) begin
            c = make_cmd({base[15:1], base[0] ^ k[0]}, 32'd0, 0, 1, k == n - 1);
            drive_ps(c, 0);
            wait_done(c, 0, ok);
            exp = (rt && k == 0) ? exp_delta : model[idx(base + k)];
            if (ok) begin
                check_val("emio_ps_in[31:0]", emio_ps_in[31:0], exp);
                check_val("blk_rt_rd", blk_rt_rd, rt);
            end
        end
        end_op(c, 0);
    endtask

    task blk_write(input logic [15:0] base, input int n, input bit rt, output int kept);
        ps_cmd_t     c;
        bit          ok;
        logic [31:0] d;
        int          w0, b0;
        ok   = 1'b1;
        kept = 0;
        w0   = wstart_cnt;
        b0   = bwen_cnt;
        for (int k = 0; k < n && ok; k++) begin
            d = $urandom;
            // rt quadlets carry a board field, about half for this board
            if (rt)
                d[11:8] = ($urandom % 2) ? board_id : board_id + 4'(1 + $urandom % 15);
            c = make_cmd({base[15:1], base[0] ^ k[0]}, d, 1, 1, k == n - 1);
            drive_ps(c, 1);
            wait_done(c, 1, ok);
            if (ok && k == 0)
                check_val("blk_wstart cycles", wstart_cnt - w0, 4);
            if (ok)
                check_val("blk_rt_wr", blk_rt_wr, rt);
            if (ok && rt && d[11:8] == board_id) begin
                model[kept] = d;
                kept++;
            end else if (ok && !rt) begin
                model[idx(base + k)] = d;
            end
        end
        end_op(c, 1);
        check_val("blk_wen pulses", bwen_cnt - b0, 1);
    endtask

    task abort_op(input logic [15:0] a, input bit is_wr);
        ps_cmd_t c;
        c = make_cmd(a, $urandom, is_wr, is_wr, 0);
        drive_ps(c, is_wr);
        repeat (3) @(posedge sysclk);
        end_op(c, is_wr);
        repeat (8) begin
            @(negedge sysclk);
            check_val("strobes", {blk_wen, blk_wstart, blk_rt_rd, blk_rt_wr, req_blk_rt_rd}, 0);
        end
    endtask

    initial begin
        int          n, kept, p0;
        logic [15:0] base;
        void'($urandom(32'h14cc));
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        pulse_cnt   = 0;
        wstart_cnt  = 0;
        bwen_cnt    = 0;
        prev_ts     = 32'd0;
        exp_delta   = 32'd0;
        contend     = 1'b0;
        rst_n       = 1'b0;
        board_id    = 4'd0;
        timestamp   = 32'd0;
        ext_req     = '0;
        emio_ps_out = 64'd0;
        emio_ps_tri = {64{1'b1}};
        for (int i = 0; i < 2 * `BANK_DEPTH; i++)
            model[i] = 32'd0;
        repeat (10) @(posedge sysclk);
        rst_n    <= 1'b1;
        board_id <= $urandom;
        contend  <= 1'b1;
        repeat (3) @(posedge sysclk);

        // quadlet writes, then read every one back
        for (int i = 0; i < 30; i++) begin
            wr_addrs[i] = rand_addr();
            quad_write(wr_addrs[i], $urandom);
        end
        for (int i = 0; i < 30; i++)
            read_check(wr_addrs[i]);

        // hub block reads
        repeat (5) begin
            n    = 2 + $urandom % 7;
            base = 16'h1000 | ($urandom % (64 - n));
            blk_read(base, n, 0);
        end

        // hub block writes with read-back
        repeat (5) begin
            n    = 2 + $urandom % 7;
            base = 16'h1000 | ($urandom % (64 - n));
            blk_write(base, n, 0, kept);
            for (int k = 0; k < n; k++)
                read_check(base + k);
        end

        // real-time block writes, kept quadlets compacted from offset 0
        repeat (4) begin
            n    = 3 + $urandom % 6;
            base = $urandom % 32;
            blk_write(base, n, 1, kept);
            for (int k = 0; k < kept; k++)
                read_check(k);
        end

        // hub trigger writes and real-time block reads
        repeat (3) begin
            repeat ($urandom % 20) @(posedge sysclk);
            p0 = pulse_cnt;
            quad_write(`HUB_TRIG_ADDR, $urandom);
            check_val("req_blk_rt_rd pulses", pulse_cnt - p0, 1);
            repeat ($urandom % 20) @(posedge sysclk);
            p0 = pulse_cnt;
            blk_read(16'h0000, 2 + $urandom % 3, 1);
            check_val("req_blk_rt_rd pulses", pulse_cnt - p0, 1);
        end

        // aborts, each followed by a normal read
        for (int i = 0; i < 4; i++) begin
            abort_op(i[0] ? 16'h1000 | ($urandom % 32) : rand_addr(), i[0]);
            read_check(wr_addrs[$urandom % 30]);
        end

        contend <= 1'b0;
        repeat (5) @(posedge sysclk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: write_addr_xlate.sv
// ----------------------------------------------------------------------
// write address translation: board-id filter and offset compaction
// for real-time block writes, plain register stage otherwise
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "emio_cfg.svh"

module write_addr_xlate import emio_pkg::*; (
    input  logic       sysclk,
    input  logic       rst_n,
    input  reg_wr_t    wr_in,
    input  logic       blk_rt_wr,
    input  logic [3:0] board_id,
    output reg_wr_t    wr_out
);

    logic [`EMIO_ADDR_W-1:0] addr_q;
    logic [`EMIO_DATA_W-1:0] data_q;
    logic                    wen_q;
    logic [7:0]              kept_cnt;
    logic                    board_match;

    // board field of each rt quadlet sits in data bits [11:8]
    assign board_match = (wr_in.data[11:8] == board_id);

    always_ff @(posedge sysclk) begin
        data_q <= wr_in.data;
        // kept quadlets land at consecutive offsets from 0
        addr_q <= blk_rt_wr ? {wr_in.addr[15:8], kept_cnt} : wr_in.addr;
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wen_q    <= 1'b0;
            kept_cnt <= 8'd0;
        end else begin
            wen_q <= wr_in.wen & (~blk_rt_wr | board_match);
            if (!blk_rt_wr)
                kept_cnt <= 8'd0;
            else if (wr_in.wen && board_match)
                kept_cnt <= kept_cnt + 8'd1;
        end
    end

    assign wr_out = '{addr: addr_q, data: data_q, wen: wen_q};

endmodule
